// ==== all.f ====
mips_pkg.sv
mips_regfile_if.sv
mips_regfile.sv
mips_program_rom.sv
mips_core.sv
mips_system.sv
mips_system_properties.sv
mips_system_tb.sv

// ==== mips_system_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_system_tb;

    import mips_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        active;
    logic        data_valid;
    logic        data_ready;
    logic        data_write;
    logic [31:0] data_address;
    logic [31:0] data_writedata;
    logic [31:0] data_readdata;

    // data memory image and the words the program loads
    logic [31:0] mem [logic [31:0]];
    logic [31:0] loaded [32];
    logic [31:0] lcg_state;

    // transfers seen on the data port, oldest first
    logic [31:0] xfer_addr_q [$];
    logic        xfer_write_q [$];
    logic [31:0] xfer_data_q [$];

    int   errors;
    int   tests_run;
    int   tests_failed;
    int   test_start_errors;
    logic stalled;

    mips_system dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .active         (active),
        .data_valid     (data_valid),
        .data_ready     (data_ready),
        .data_write     (data_write),
        .data_address   (data_address),
        .data_writedata (data_writedata),
        .data_readdata  (data_readdata)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic fill_memory();
        for (int k = 0; k <= last_reg - first_reg; k++) begin
            lcg_state = lcg_next(lcg_state);
            loaded[k] = lcg_state;
            mem[load_base + 32'(4 * k)] = lcg_state;
        end
    endtask

    // memory model drives ready and read data for the next rising edge
    always @(negedge clk) begin
        if (rst_n) begin
            lcg_state     = lcg_next(lcg_state);
            data_ready    = lcg_state[20];
            data_readdata = 32'h0;
            if (data_valid && data_ready) begin
                if (data_write) begin
                    mem[data_address] = data_writedata;
                end else if (mem.exists(data_address)) begin
                    data_readdata = mem[data_address];
                end
                xfer_addr_q.push_back(data_address);
                xfer_write_q.push_back(data_write);
                xfer_data_q.push_back(data_write ? data_writedata : data_readdata);
            end
        end
    end

    task automatic check_value(input string sig, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s expected %h got %h", sig, expected, actual);
            errors++;
        end
    endtask

    task automatic next_transfer(input string what, output logic [31:0] addr,
                                 output logic wr, output logic [31:0] wdata);
        int cycles;
        cycles = 0;
        addr   = '0;
        wr     = 1'b0;
        wdata  = '0;
        while ((xfer_addr_q.size() == 0) && (cycles < 200)) begin
            @(posedge clk);
            cycles++;
        end
        if (xfer_addr_q.size() == 0) begin
            $display("timeout: %s stalled, no data transfer within 200 cycles", what);
            stalled = 1'b1;
            errors++;
        end else begin
            addr  = xfer_addr_q.pop_front();
            wr    = xfer_write_q.pop_front();
            wdata = xfer_data_q.pop_front();
        end
    endtask

    task automatic finish_test(input int num, input string name);
        tests_run++;
        if (errors != test_start_errors) begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", num, name,
                     errors - test_start_errors);
        end else if (stalled) begin
            $display("test %0d %s: not run after an earlier stall", num, name);
        end else begin
            $display("test %0d %s: ok", num, name);
        end
    endtask

    task automatic reset_state_and_first_read();
        logic [31:0] addr;
        logic        wr;
        logic [31:0] data;
        test_start_errors = errors;
        check_value("active", 32'h1, 32'(active));
        check_value("data_valid", 32'h0, 32'(data_valid));
        next_transfer("test 1 first read", addr, wr, data);
        if (!stalled) begin
            check_value("data_address", load_base, addr);
            check_value("data_write", 32'h0, 32'(wr));
        end
        finish_test(1, "reset state and first read");
    endtask

    task automatic ascending_load_sequence();
        logic [31:0] addr;
        logic        wr;
        logic [31:0] data;
        test_start_errors = errors;
        for (int k = 1; (k <= last_reg - first_reg) && !stalled; k++) begin
            next_transfer("test 2 load sequence", addr, wr, data);
            if (!stalled) begin
                check_value("data_address", load_base + 32'(4 * k), addr);
                check_value("data_write", 32'h0, 32'(wr));
            end
        end
        finish_test(2, "ascending loads");
    endtask

    task automatic incremented_store_sequence();
        logic [31:0] addr;
        logic        wr;
        logic [31:0] data;
        logic [31:0] offset;
        logic [31:0] expected;
        test_start_errors = errors;
        for (int k = 0; (k <= last_reg - first_reg) && !stalled; k++) begin
            next_transfer("test 3 store sequence", addr, wr, data);
            if (!stalled) begin
                // addiu only sees the sign-extended low half of the step
                offset   = imm_step * 32'(k);
                expected = loaded[k] + {{16{offset[15]}}, offset[15:0]};
                check_value("data_address", store_base + 32'(4 * k), addr);
                check_value("data_write", 32'h1, 32'(wr));
                check_value("data_writedata", expected, data);
            end
        end
        finish_test(3, "stores of incremented words");
    endtask

    task automatic halt_after_last_store();
        int cycles;
        test_start_errors = errors;
        cycles = 0;
        if (!stalled) begin
            while (active && (cycles < 100)) begin
                @(negedge clk);
                cycles++;
            end
            if (active) begin
                $display("timeout: test 4 halt, active still high 100 cycles after last store");
                stalled = 1'b1;
                errors++;
            end else begin
                // the core must stay quiet once it has halted
                for (int c = 0; c < 50; c++) begin
                    @(negedge clk);
                    check_value("data_valid", 32'h0, 32'(data_valid));
                    check_value("active", 32'h0, 32'(active));
                end
                check_value("data transfer count", 32'h0, 32'(xfer_addr_q.size()));
            end
        end
        finish_test(4, "halt after jr r0");
    endtask

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        data_ready    = 1'b0;
        data_readdata = 32'h0;
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        stalled       = 1'b0;
        lcg_state     = 32'hed2;
        fill_memory();

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n <= 1'b1;

        reset_state_and_first_read();
        ascending_load_sequence();
        incremented_store_sequence();
        halt_after_last_store();

        $display("tests run %0d, tests failed %0d, check errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, dut_i.props_i.failures);
        if ((errors == 0) && (dut_i.props_i.failures == 0)) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== mips_system_properties.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_system_properties (
    input wire logic                 clk,
    input wire logic                 rst_n,
    input wire logic                 active,
    input wire logic                 data_valid,
    input wire logic                 data_ready,
    input wire logic                 data_write,
    input wire logic [31:0]          data_address,
    input wire logic [31:0]          data_writedata,
    input wire mips_pkg::core_state_e core_state
);

    import mips_pkg::*;

    int failures = 0;

    // checked from the second reset cycle on when the state is known
    no_request_in_reset: assert property (
        @(posedge clk) (!rst_n && $past(!rst_n)) |-> !data_valid
    ) else begin
        $error("data_valid high during reset");
        failures++;
    end

    // a stalled request keeps every field until it is taken
    request_held_under_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        (data_valid && !data_ready) |=>
            (data_valid && $stable(data_write) && $stable(data_address)
             && $stable(data_writedata))
    ) else begin
        $error("data request changed before transfer");
        failures++;
    end

    no_request_when_inactive: assert property (
        @(posedge clk) disable iff (!rst_n)
        !active |-> !data_valid
    ) else begin
        $error("data_valid high while inactive");
        failures++;
    end

    active_stays_low: assert property (
        @(posedge clk) disable iff (!rst_n)
        !active |=> !active
    ) else begin
        $error("active rose again without reset");
        failures++;
    end

    // a register writeback only follows a completed read
    writeback_after_read: assert property (
        @(posedge clk) disable iff (!rst_n)
        (core_state == writeback) |-> $past(data_valid && data_ready && !data_write)
    ) else begin
        $error("writeback without a preceding read transfer");
        failures++;
    end

endmodule

bind mips_system mips_system_properties props_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .active         (active),
    .data_valid     (data_valid),
    .data_ready     (data_ready),
    .data_write     (data_write),
    .data_address   (data_address),
    .data_writedata (data_writedata),
    .core_state     (core_i.state)
);

`default_nettype wire

// ==== mips_system.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_system (
    input  wire logic        clk,
    input  wire logic        rst_n,
    output logic             active,
    output logic             data_valid,
    input  wire logic        data_ready,
    output logic             data_write,
    output logic [31:0]      data_address,
    output logic [31:0]      data_writedata,
    input  wire logic [31:0] data_readdata
);

    import mips_pkg::*;

    // instruction fetch link
    logic [31:0] instr_address;
    instr_word_u instr_readdata;

    mips_regfile_if rf_if ();

    mips_core core_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .active         (active),
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata),
        .rf             (rf_if.core),
        .data_valid     (data_valid),
        .data_ready     (data_ready),
        .data_write     (data_write),
        .data_address   (data_address),
        .data_writedata (data_writedata),
        .data_readdata  (data_readdata)
    );

    mips_program_rom rom_i (
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata)
    );

    mips_regfile regfile_i (
        .clk   (clk),
        .rst_n (rst_n),
        .rf    (rf_if.regfile)
    );

endmodule

`default_nettype wire

// ==== mips_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_core (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    output logic                       active,
    output logic [31:0]                instr_address,
    input  wire mips_pkg::instr_word_u instr_readdata,
    mips_regfile_if.core               rf,
    output logic                       data_valid,
    input  wire logic                  data_ready,
    output logic                       data_write,
    output logic [31:0]                data_address,
    output logic [31:0]                data_writedata,
    input  wire logic [31:0]           data_readdata
);

    import mips_pkg::*;

    core_state_e state;
    logic [31:0] pc;

    // payload registers
    instr_word_u instr_q;
    logic [31:0] addr_q;
    logic [31:0] load_q;

    // decode results
    logic is_lw;
    logic is_sw;
    logic is_addiu;
    logic is_jr;

    logic [31:0] sign_imm;
    logic [31:0] sum;

    always_comb begin
        is_lw    = 1'b0;
        is_sw    = 1'b0;
        is_addiu = 1'b0;
        is_jr    = 1'b0;
        case (instr_q.i.opcode)
            op_lw:      is_lw    = 1'b1;
            op_sw:      is_sw    = 1'b1;
            op_addiu:   is_addiu = 1'b1;
            op_special: is_jr    = (instr_q.r.funct == funct_jr);
            default:    ;
        endcase
    end

    // rs and rt sit in the same bits in every format
    assign rf.rs_addr = instr_q.i.rs;
    assign rf.rt_addr = instr_q.i.rt;

    // the only adder, shared by addiu and address generation
    assign sign_imm = {{16{instr_q.i.imm[15]}}, instr_q.i.imm};
    assign sum      = rf.rs_data + sign_imm;

    // register write port
    always_comb begin
        rf.wr_en   = 1'b0;
        rf.wr_addr = instr_q.i.rt;
        rf.wr_data = sum;
        if ((state == execute) && is_addiu) begin
            rf.wr_en = 1'b1;
        end else if (state == writeback) begin
            rf.wr_en   = 1'b1;
            rf.wr_data = load_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= fetch;
            pc    <= prog_start;
        end else begin
            unique case (state)
                fetch: begin
                    state <= execute;
                end
                execute: begin
                    if (is_jr) begin
                        pc <= rf.rs_data;
                        // jumping to zero means the program is done
                        state <= (rf.rs_data == '0) ? halted : fetch;
                    end else begin
                        pc    <= pc + 32'd4;
                        state <= (is_lw || is_sw) ? memory : fetch;
                    end
                end
                memory: begin
                    // wait here for as long as the memory stalls
                    if (data_ready) begin
                        state <= is_lw ? writeback : fetch;
                    end
                end
                writeback: begin
                    state <= fetch;
                end
                halted: begin
                    state <= halted;
                end
            endcase
        end
    end

    // instruction latched on the fetch cycle
    always_ff @(posedge clk) begin
        if (state == fetch) begin
            instr_q <= instr_readdata;
        end
    end

    // effective address held through the whole request
    always_ff @(posedge clk) begin
        if (state == execute) begin
            addr_q <= sum;
        end
    end

    // read data is only valid on the transfer edge
    always_ff @(posedge clk) begin
        if ((state == memory) && data_ready) begin
            load_q <= data_readdata;
        end
    end

    assign active        = (state != halted);
    assign instr_address = pc;

    assign data_valid   = (state == memory);
    assign data_write   = is_sw;
    assign data_address = addr_q;
    // rt is not written while a request is pending, so this stays stable
    assign data_writedata = rf.rt_data;

endmodule

`default_nettype wire

// ==== mips_program_rom.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_program_rom (
    input  wire logic [31:0]           instr_address,
    output mips_pkg::instr_word_u      instr_readdata
);

    import mips_pkg::*;

    instr_word_u rom [rom_words];

    initial begin
        instr_word_u w;
        int unsigned idx;

        // anything not written below decodes as sll r0, r0, 0
        for (int k = 0; k < rom_words; k++) begin
            rom[k] = '0;
        end

        idx = prog_start >> 2;

        // lw ri, load_base+4(i-2)(r0)
        for (int r = first_reg; r <= last_reg; r++) begin
            w          = '0;
            w.i.opcode = op_lw;
            w.i.rs     = 5'd0;
            w.i.rt     = 5'(r);
            w.i.imm    = 16'(load_base + 32'(4 * (r - first_reg)));
            rom[idx]   = w;
            idx++;
        end

        // addiu ri, ri, imm_step*(i-2), only the low half survives
        for (int r = first_reg; r <= last_reg; r++) begin
            w          = '0;
            w.i.opcode = op_addiu;
            w.i.rs     = 5'(r);
            w.i.rt     = 5'(r);
            w.i.imm    = 16'(imm_step * 32'(r - first_reg));
            rom[idx]   = w;
            idx++;
        end

        // sw ri, store_base+4(i-2)(r0)
        for (int r = first_reg; r <= last_reg; r++) begin
            w          = '0;
            w.i.opcode = op_sw;
            w.i.rs     = 5'd0;
            w.i.rt     = 5'(r);
            w.i.imm    = 16'(store_base + 32'(4 * (r - first_reg)));
            rom[idx]   = w;
            idx++;
        end

        // jr r0 ends the program
        w          = '0;
        w.r.opcode = op_special;
        w.r.rs     = 5'd0;
        w.r.funct  = funct_jr;
        rom[idx]   = w;
    end

    // word addressed, byte offset bits dropped
    assign instr_readdata = rom[instr_address[rom_addr_bits+1:2]];

endmodule

`default_nettype wire

// ==== mips_regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_regfile (
    input  wire logic       clk,
    input  wire logic       rst_n,
    mips_regfile_if.regfile rf
);

    logic [31:0] regs [32];

    // write lands on the clock edge, r0 is never written
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (rf.wr_en && (rf.wr_addr != 5'd0)) begin
            regs[rf.wr_addr] <= rf.wr_data;
        end
    end

    // combinational reads with r0 forced to zero
    always_comb begin
        if (rf.rs_addr == 5'd0) begin
            rf.rs_data = '0;
        end else begin
            rf.rs_data = regs[rf.rs_addr];
        end
    end

    always_comb begin
        if (rf.rt_addr == 5'd0) begin
            rf.rt_data = '0;
        end else begin
            rf.rt_data = regs[rf.rt_addr];
        end
    end

endmodule

`default_nettype wire

// ==== mips_regfile_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface mips_regfile_if;

    // two read ports, addressed by rs and rt
    logic [4:0]  rs_addr;
    logic [4:0]  rt_addr;
    logic [31:0] rs_data;
    logic [31:0] rt_data;

    // single write port
    logic        wr_en;
    logic [4:0]  wr_addr;
    logic [31:0] wr_data;

    modport core (
        output rs_addr, rt_addr,
        input  rs_data, rt_data,
        output wr_en, wr_addr, wr_data
    );

    modport regfile (
        input  rs_addr, rt_addr,
        output rs_data, rt_data,
        input  wr_en, wr_addr, wr_data
    );

endinterface

`default_nettype wire

// ==== mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    // opcode and function codes of the supported subset
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] funct_jr   = 6'h08;

    // program ROM geometry
    localparam int unsigned rom_words     = 4096;
    localparam int unsigned rom_addr_bits = $clog2(rom_words);

    // reset PC, the word at address zero is where the final jr lands
    localparam logic [31:0] prog_start = 32'h0000_0004;

    // data layout used by the test program
    localparam logic [31:0] load_base  = 32'h0000_0400;
    localparam logic [31:0] store_base = 32'h0000_0480;
    localparam logic [31:0] imm_step   = 32'h0000_1111;

    // registers touched by the program
    localparam int first_reg = 2;
    localparam int last_reg  = 31;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_type_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_type_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } j_type_t;

    // one instruction word seen in its three encodings
    typedef union packed {
        r_type_t r;
        i_type_t i;
        j_type_t j;
    } instr_word_u;

    typedef enum logic [2:0] {
        fetch,
        execute,
        memory,
        writeback,
        halted
    } core_state_e;

endpackage

`default_nettype wire
